// ==== design/uart_pkg.sv ====
// Shared widths, host register map and state types for the UART peripheral
// Every RTL module that needs one of these takes them by a wildcard import
package uart_pkg;

	// Data and address widths
	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;

	//////////////////////////////////////////////////
	// Host register map
	//////////////////////////////////////////////////
	// Write sends a byte, read returns the last received byte
	localparam addr_t DATA_ADDR = 16'h9000;
	// Read returns flags, write sets the interrupt enables
	localparam addr_t STAT_ADDR = 16'h9001;

	// Status byte bit positions, others read 0
	localparam int ST_RX_VALID = 0;
	localparam int ST_TX_READY = 1;
	localparam int ST_OVERRUN  = 2;
	localparam int ST_IE_RX    = 6;
	localparam int ST_IE_TX    = 7;

	//////////////////////////////////////////////////
	// State and access types
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_CLEANUP} rx_state_t;

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP, TX_CLEANUP} tx_state_t;

	// Decoded kind of a host access
	typedef enum logic [1:0] {ACC_NONE, ACC_DATA, ACC_STAT} reg_access_t;

endpackage

// ==== design/baud_timer.sv ====
// Clock counter for one serial bit period
// Flags the mid-bit and end-of-bit points for the RX and TX state machines
`timescale 1ns/1ns

module baud_timer #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic r_Clock,
	input  logic rx_dv,
	input  logic i_clear,
	output logic o_mid,
	output logic o_bit_end
);

	// Wide enough to hold CLKS_PER_BIT-1
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'((CLKS_PER_BIT - 1) / 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] r_count;

	// Restart on clear, wrap at end of bit
	always_ff @(posedge r_Clock or posedge rx_dv)
	begin
		if (rx_dv)
			r_count <= '0;
		else if (i_clear || o_bit_end)
			r_count <= '0;
		else
			r_count <= r_count + 1'b1;
	end

	// Decoded from the registered count
	assign o_mid     = (r_count == MID_CNT);
	assign o_bit_end = (r_count == LAST_CNT);

endmodule

// ==== design/uart_rx.sv ====
// 8N1 serial receiver with a two-flop input synchronizer
// Strobes o_rx_strobe for one cycle at mid stop bit with the byte on o_rx_byte
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic  r_Clock,
	input  logic  rx_dv,
	input  logic  i_rx_serial,
	output logic  o_rx_strobe,
	output byte_t o_rx_byte
);

	localparam int IDX_W = $clog2(DATA_W);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

	// Synchronizer stages, idle line level after reset
	logic r_rx_meta;
	logic r_rx_bit;

	rx_state_t        r_state;
	logic [IDX_W-1:0] r_bit_idx;
	byte_t            r_shift;

	logic w_clear;
	logic w_mid;
	logic w_bit_end;

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////
	always_ff @(posedge r_Clock or posedge rx_dv)
	begin
		if (rx_dv)
		begin
			r_rx_meta <= 1'b1;
			r_rx_bit  <= 1'b1;
		end
		else
		begin
			r_rx_meta <= i_rx_serial;
			r_rx_bit  <= r_rx_meta;
		end
	end

	// Held at zero in idle, realigned when the start bit is confirmed
	assign w_clear = (r_state == RX_IDLE) || (r_state == RX_START && w_mid && !r_rx_bit);

	baud_timer #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) baud_timer_i (
		.r_Clock  (r_Clock),
		.rx_dv    (rx_dv),
		.i_clear  (w_clear),
		.o_mid    (w_mid),
		.o_bit_end(w_bit_end)
	);

	//////////////////////////////////////////////////
	// Receive FSM
	//////////////////////////////////////////////////
	always_ff @(posedge r_Clock or posedge rx_dv)
	begin
		if (rx_dv)
		begin
			r_state     <= RX_IDLE;
			r_bit_idx   <= '0;
			o_rx_strobe <= 1'b0;
		end
		else
		begin
			o_rx_strobe <= 1'b0;
			case (r_state)
				RX_IDLE:
				begin
					r_bit_idx <= '0;
					// Falling edge of the start bit
					if (!r_rx_bit)
						r_state <= RX_START;
				end
				RX_START:
				begin
					// Still low at mid-start, otherwise a glitch
					if (w_mid)
						r_state <= r_rx_bit ? RX_IDLE : RX_DATA;
				end
				RX_DATA:
				begin
					if (w_bit_end)
					begin
						r_bit_idx <= r_bit_idx + 1'b1;
						if (r_bit_idx == LAST_IDX)
							r_state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					// Mid stop bit, value not checked
					if (w_bit_end)
					begin
						o_rx_strobe <= 1'b1;
						r_state     <= RX_CLEANUP;
					end
				end
				RX_CLEANUP:
					r_state <= RX_IDLE;
				default:
					r_state <= RX_IDLE;
			endcase
		end
	end

	// Deserializer, LSB arrives first and ends up in bit 0
	always_ff @(posedge r_Clock)
	begin
		if (r_state == RX_DATA && w_bit_end)
			r_shift <= {r_rx_bit, r_shift[DATA_W-1:1]};
	end

	assign o_rx_byte = r_shift;

	// One strobe per frame
	a_strobe_single: assert property (@(posedge r_Clock) disable iff (rx_dv)
		o_rx_strobe |=> !o_rx_strobe)
		else $error("uart_rx: o_rx_strobe high for two cycles");

endmodule

// ==== design/uart_tx.sv ====
// 8N1 serial transmitter
// Takes a start strobe only while idle and sends start, 8 data bits LSB first, stop
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic  r_Clock,
	input  logic  rx_dv,
	input  logic  i_tx_start,
	input  byte_t i_tx_byte,
	output logic  o_tx_busy,
	output logic  o_tx_serial
);

	localparam int IDX_W = $clog2(DATA_W);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

	tx_state_t        r_state;
	logic [IDX_W-1:0] r_bit_idx;
	byte_t            r_shift;

	logic w_clear;
	logic w_bit_end;

	// Timer parked at zero so the start bit gets a full period
	assign w_clear = (r_state == TX_IDLE);

	baud_timer #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) baud_timer_i (
		.r_Clock  (r_Clock),
		.rx_dv    (rx_dv),
		.i_clear  (w_clear),
		.o_mid    (),
		.o_bit_end(w_bit_end)
	);

	//////////////////////////////////////////////////
	// Transmit FSM
	//////////////////////////////////////////////////
	always_ff @(posedge r_Clock or posedge rx_dv)
	begin
		if (rx_dv)
		begin
			r_state     <= TX_IDLE;
			r_bit_idx   <= '0;
			o_tx_serial <= 1'b1;
		end
		else
		begin
			case (r_state)
				TX_IDLE:
				begin
					r_bit_idx <= '0;
					// Start bit goes out on the same edge
					if (i_tx_start)
					begin
						o_tx_serial <= 1'b0;
						r_state     <= TX_START;
					end
				end
				TX_START:
				begin
					if (w_bit_end)
					begin
						o_tx_serial <= r_shift[0];
						r_state     <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (w_bit_end)
					begin
						r_bit_idx <= r_bit_idx + 1'b1;
						if (r_bit_idx == LAST_IDX)
						begin
							// Stop bit
							o_tx_serial <= 1'b1;
							r_state     <= TX_STOP;
						end
						else
							o_tx_serial <= r_shift[0];
					end
				end
				TX_STOP:
				begin
					if (w_bit_end)
						r_state <= TX_CLEANUP;
				end
				// One extra cycle before the next frame
				TX_CLEANUP:
					r_state <= TX_IDLE;
				default:
					r_state <= TX_IDLE;
			endcase
		end
	end

	// Serializer, bit 0 is always the next bit to send
	always_ff @(posedge r_Clock)
	begin
		if (r_state == TX_IDLE && i_tx_start)
			r_shift <= i_tx_byte;
		else if (w_bit_end && (r_state == TX_START || r_state == TX_DATA))
			r_shift <= {1'b0, r_shift[DATA_W-1:1]};
	end

	assign o_tx_busy = (r_state != TX_IDLE);

	a_idle_high: assert property (@(posedge r_Clock) disable iff (rx_dv)
		(r_state == TX_IDLE) |-> o_tx_serial)
		else $error("uart_tx: line low while idle");

endmodule

// ==== design/uart_regs.sv ====
// Host register block: data and status registers, RX flags and interrupt logic
// Single-cycle read and write strobes, read data registered one cycle later
`timescale 1ns/1ns

module uart_regs import uart_pkg::*; (
	input  logic  r_Clock,
	input  logic  rx_dv,
	// Host port
	input  addr_t i_addr,
	input  byte_t i_wdata,
	input  logic  i_wr,
	input  logic  i_rd,
	output byte_t o_rdata,
	// Receiver side
	input  logic  i_rx_strobe,
	input  byte_t i_rx_byte,
	// Transmitter side
	input  logic  i_tx_busy,
	output logic  o_tx_start,
	output byte_t o_tx_byte,
	output logic  o_irq
);

	reg_access_t w_acc;
	logic        w_data_rd;
	logic        w_data_wr;
	logic        w_stat_wr;
	logic        w_tx_ready;
	byte_t       w_status;

	// Received byte and its flags
	byte_t r_rx_byte;
	logic  r_rx_valid;
	logic  r_overrun;

	// Interrupt enables
	logic r_ie_rx;
	logic r_ie_tx;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////
	always_comb
	begin
		if (i_addr == DATA_ADDR)
			w_acc = ACC_DATA;
		else if (i_addr == STAT_ADDR)
			w_acc = ACC_STAT;
		else
			w_acc = ACC_NONE;
	end

	assign w_data_rd = i_rd && (w_acc == ACC_DATA);
	assign w_data_wr = i_wr && (w_acc == ACC_DATA);
	assign w_stat_wr = i_wr && (w_acc == ACC_STAT);

	// A start strobe still in flight counts as busy
	assign w_tx_ready = !(i_tx_busy || o_tx_start);

	// Status byte
	always_comb
	begin
		w_status              = '0;
		w_status[ST_RX_VALID] = r_rx_valid;
		w_status[ST_TX_READY] = w_tx_ready;
		w_status[ST_OVERRUN]  = r_overrun;
		w_status[ST_IE_RX]    = r_ie_rx;
		w_status[ST_IE_TX]    = r_ie_tx;
	end

	//////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////
	always_ff @(posedge r_Clock or posedge rx_dv)
	begin
		if (rx_dv)
		begin
			o_rdata    <= '0;
			r_rx_valid <= 1'b0;
			r_overrun  <= 1'b0;
			r_ie_rx    <= 1'b0;
			r_ie_tx    <= 1'b0;
			o_tx_start <= 1'b0;
		end
		else
		begin
			// Read data, held until the next read
			if (i_rd)
			begin
				case (w_acc)
					ACC_DATA: o_rdata <= r_rx_byte;
					ACC_STAT: o_rdata <= w_status;
					default:  o_rdata <= '0;
				endcase
			end

			// New byte wins over a data read in the same cycle
			if (i_rx_strobe)
			begin
				r_rx_valid <= 1'b1;
				r_overrun  <= r_rx_valid && !w_data_rd;
			end
			else if (w_data_rd)
			begin
				r_rx_valid <= 1'b0;
				r_overrun  <= 1'b0;
			end

			if (w_stat_wr)
			begin
				r_ie_rx <= i_wdata[ST_IE_RX];
				r_ie_tx <= i_wdata[ST_IE_TX];
			end

			// One-cycle kick to the transmitter
			o_tx_start <= w_data_wr;
		end
	end

	// Payload holding registers
	always_ff @(posedge r_Clock)
	begin
		if (i_rx_strobe)
			r_rx_byte <= i_rx_byte;
		if (w_data_wr)
			o_tx_byte <= i_wdata;
	end

	assign o_irq = (r_ie_tx && w_tx_ready) || (r_ie_rx && r_rx_valid);

	a_no_rd_wr: assert property (@(posedge r_Clock) disable iff (rx_dv)
		!(i_wr && i_rd))
		else $error("uart_regs: read and write strobes together");

endmodule

// ==== design/uart_periph.sv ====
// UART peripheral top level
// Host register port on one side, serial RX/TX lines and the interrupt on the other
`timescale 1ns/1ns

module uart_periph import uart_pkg::*; #(
	// 50 MHz at 115200 baud
	parameter int CLKS_PER_BIT = 434
) (
	input  logic  r_Clock,
	input  logic  rx_dv,
	input  addr_t i_addr,
	input  byte_t i_wdata,
	input  logic  i_wr,
	input  logic  i_rd,
	output byte_t o_rdata,
	input  logic  i_rx_serial,
	output logic  o_tx_serial,
	output logic  o_irq
);

	// Register block to transmitter
	logic  w_tx_start;
	byte_t w_tx_byte;
	logic  w_tx_busy;

	// Receiver to register block
	logic  w_rx_strobe;
	byte_t w_rx_byte;

	uart_regs uart_regs_i (
		.r_Clock    (r_Clock),
		.rx_dv      (rx_dv),
		.i_addr     (i_addr),
		.i_wdata    (i_wdata),
		.i_wr       (i_wr),
		.i_rd       (i_rd),
		.o_rdata    (o_rdata),
		.i_rx_strobe(w_rx_strobe),
		.i_rx_byte  (w_rx_byte),
		.i_tx_busy  (w_tx_busy),
		.o_tx_start (w_tx_start),
		.o_tx_byte  (w_tx_byte),
		.o_irq      (o_irq)
	);

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_rx_i (
		.r_Clock    (r_Clock),
		.rx_dv      (rx_dv),
		.i_rx_serial(i_rx_serial),
		.o_rx_strobe(w_rx_strobe),
		.o_rx_byte  (w_rx_byte)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_tx_i (
		.r_Clock    (r_Clock),
		.rx_dv      (rx_dv),
		.i_tx_start (w_tx_start),
		.i_tx_byte  (w_tx_byte),
		.o_tx_busy  (w_tx_busy),
		.o_tx_serial(o_tx_serial)
	);

endmodule

// ==== tb/uart_periph_tb.sv ====
// Self-checking testbench for the UART peripheral
// Replays tb/uart_golden.dat against the DUT: host accesses, RX frames, TX frames, interrupt
`timescale 1ns/1ns

module uart_periph_tb import uart_pkg::*; ();

	localparam int    CLKS_PER_BIT = 8;
	localparam string GOLDEN       = "tb/uart_golden.dat";

	logic  r_Clock;
	logic  rx_dv;
	addr_t i_addr;
	byte_t i_wdata;
	logic  i_wr;
	logic  i_rd;
	byte_t o_rdata;
	logic  i_rx_serial;
	logic  o_tx_serial;
	logic  o_irq;

	// Bytes decoded from o_tx_serial, oldest first
	byte_t tx_q[$];

	int cycle_cnt   = 0;
	int cycle_limit = 0;

	uart_periph #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_periph_i (
		.r_Clock    (r_Clock),
		.rx_dv      (rx_dv),
		.i_addr     (i_addr),
		.i_wdata    (i_wdata),
		.i_wr       (i_wr),
		.i_rd       (i_rd),
		.o_rdata    (o_rdata),
		.i_rx_serial(i_rx_serial),
		.o_tx_serial(o_tx_serial),
		.o_irq      (o_irq)
	);

	// 4 ns clock
	initial
	begin
		r_Clock = 1'b0;
		forever
			#2 r_Clock = ~r_Clock;
	end

	//////////////////////////////////////////////////
	// Error handling and compares
	//////////////////////////////////////////////////
	task automatic error_stop(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			error_stop($sformatf("ERR %0t: %s got 0x%02h, expected 0x%02h", $time, what, got, exp));
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp)
			error_stop($sformatf("ERR %0t: o_irq is %b, expected %b", $time, got, exp));
	endtask

	task automatic check_line(input logic got, input logic exp, input string what);
		if (got !== exp)
			error_stop($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// Hang guard, limit set once the golden file is sized
	always @(posedge r_Clock)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit)
			error_stop($sformatf("Timeout: no progress after %0d clock cycles", cycle_cnt));
	end

	//////////////////////////////////////////////////
	// Host bus and serial line drivers
	//////////////////////////////////////////////////
	task automatic write_reg(input addr_t a, input byte_t d);
		@(posedge r_Clock);
		i_addr  <= a;
		i_wdata <= d;
		i_wr    <= 1'b1;
		@(posedge r_Clock);
		i_wr <= 1'b0;
	endtask

	task automatic read_reg(input addr_t a, input byte_t exp);
		@(posedge r_Clock);
		i_addr <= a;
		i_rd   <= 1'b1;
		@(posedge r_Clock);
		i_rd <= 1'b0;
		// Registered read data, settled by the falling edge
		@(negedge r_Clock);
		check_byte(o_rdata, exp, $sformatf("read of 0x%04h", a));
	endtask

	// Start bit, 8 data bits LSB first, stop bit, then 2 idle bit periods
	task automatic send_frame(input byte_t b);
		int i;
		@(posedge r_Clock);
		i_rx_serial <= 1'b0;
		repeat (CLKS_PER_BIT) @(posedge r_Clock);
		for (i = 0; i < DATA_W; i++)
		begin
			i_rx_serial <= b[i];
			repeat (CLKS_PER_BIT) @(posedge r_Clock);
		end
		i_rx_serial <= 1'b1;
		repeat (3 * CLKS_PER_BIT) @(posedge r_Clock);
	endtask

	// Next decoded TX byte, then let the stop bit and cleanup finish
	task automatic expect_frame(input byte_t exp);
		byte_t got;
		while (tx_q.size() == 0)
			@(negedge r_Clock);
		got = tx_q.pop_front();
		check_byte(got, exp, "TX frame");
		repeat (CLKS_PER_BIT) @(posedge r_Clock);
	endtask

	// Comment lines in the golden file
	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != "\n" && ch != -1)
			ch = $fgetc(fd);
	endtask

	//////////////////////////////////////////////////
	// TX line monitor
	//////////////////////////////////////////////////
	initial
	begin : tx_monitor
		byte_t bits;
		int    i;
		wait (rx_dv === 1'b0);
		forever
		begin
			@(negedge r_Clock);
			// Falling edge of a start bit
			if (o_tx_serial === 1'b0)
			begin
				repeat (CLKS_PER_BIT / 2) @(negedge r_Clock);
				check_line(o_tx_serial, 1'b0, "TX start bit at mid-bit");
				for (i = 0; i < DATA_W; i++)
				begin
					repeat (CLKS_PER_BIT) @(negedge r_Clock);
					bits[i] = o_tx_serial;
				end
				repeat (CLKS_PER_BIT) @(negedge r_Clock);
				check_line(o_tx_serial, 1'b1, "TX stop bit at mid-bit");
				tx_q.push_back(bits);
			end
		end
	end

	//////////////////////////////////////////////////
	// Golden file replay
	//////////////////////////////////////////////////
	initial
	begin : golden_replay
		int         fd;
		int         ch;
		int         code;
		int         n_lines;
		logic [7:0] cmd;
		addr_t      f_addr;
		byte_t      f_val;
		bit         done;

		i_addr      = '0;
		i_wdata     = '0;
		i_wr        = 1'b0;
		i_rd        = 1'b0;
		i_rx_serial = 1'b1;
		rx_dv       = 1'b1;
		n_lines     = 0;
		done        = 1'b0;

		// Size the timeout from the file length
		fd = $fopen(GOLDEN, "r");
		if (fd == 0)
			error_stop("Could not open the golden file tb/uart_golden.dat");
		ch = $fgetc(fd);
		while (ch != -1)
		begin
			if (ch == "\n")
				n_lines++;
			ch = $fgetc(fd);
		end
		$fclose(fd);
		cycle_limit = n_lines * 12 * CLKS_PER_BIT + 100;

		repeat (4) @(posedge r_Clock);
		rx_dv <= 1'b0;
		@(negedge r_Clock);
		check_line(o_tx_serial, 1'b1, "TX line after reset");

		fd = $fopen(GOLDEN, "r");
		if (fd == 0)
			error_stop("Could not reopen the golden file tb/uart_golden.dat");
		while (!done)
		begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
				done = 1'b1;
			else
			begin
				case (cmd)
					"#": skip_line(fd);
					"W", "R":
					begin
						code = $fscanf(fd, "%h %h", f_addr, f_val);
						if (code != 2)
							error_stop("Golden file line is missing its address or data field");
						if (cmd == "W")
							write_reg(f_addr, f_val);
						else
							read_reg(f_addr, f_val);
					end
					"S", "T", "I":
					begin
						code = $fscanf(fd, "%h", f_val);
						if (code != 1)
							error_stop("Golden file line is missing its value field");
						if (cmd == "S")
							send_frame(f_val);
						else if (cmd == "T")
							expect_frame(f_val);
						else
						begin
							@(negedge r_Clock);
							check_irq(o_irq, f_val[0]);
						end
					end
					default:
						error_stop($sformatf("Unknown command letter '%c' in the golden file", cmd));
				endcase
			end
		end
		$fclose(fd);

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== uart_bus.f ====
design/uart_pkg.sv
design/baud_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_regs.sv
design/uart_periph.sv
tb/uart_periph_tb.sv

// ==== tb/uart_golden.dat ====
# Columns: command letter, then hex fields. W addr data, R addr expected, S byte, T byte, I level
# W writes, R reads and compares, S sends an RX frame, T checks the next TX frame, I checks o_irq
# After reset only tx-ready is set
R 9001 02
I 0
# One TX byte, busy right after the write
W 9000 A5
R 9001 00
T A5
R 9001 02
# One RX byte
S 3C
R 9001 03
R 9000 3C
R 9001 02
# Two RX bytes without a read give overrun
S 11
S 22
R 9001 07
R 9000 22
R 9001 02
# RX interrupt
W 9001 40
I 0
S 77
I 1
R 9001 43
R 9000 77
I 0
# TX interrupt while idle
W 9001 80
I 1
R 9001 82
W 9001 00
I 0
# Write during a frame is lost
W 9000 5A
W 9000 C3
T 5A
W 9000 96
T 96
R 9001 02
